//--- rtl/wbuf_consts.svh
// sizing constants for the store buffer, included by the package and the testbench
`ifndef WBUF_CONSTS_SVH
`define WBUF_CONSTS_SVH

////////////////////
// buffer geometry
////////////////////

// number of word entries in the buffer
`define WBUF_DEPTH 4

// write transactions that may be outstanding at once
`define WBUF_MAX_TX 2

////////////////////
// datapath widths
////////////////////

`define WBUF_ADDR_W 32
`define WBUF_DATA_W 64
`define WBUF_BE_W 8

// word address, byte offset bits stripped
`define WBUF_WTAG_W (`WBUF_ADDR_W - 3)

`endif

//--- rtl/wbuf_pkg.sv
// shared types of the store buffer, imported by every stage and by the top level
`include "wbuf_consts.svh"

package wbuf_pkg;

  // entry index and transaction id
  typedef logic [$clog2(`WBUF_DEPTH)-1:0]  wbuf_ptr_t;
  typedef logic [$clog2(`WBUF_MAX_TX)-1:0] wbuf_id_t;
  typedef logic [`WBUF_BE_W-1:0]           wbuf_be_t;

  // core write, byte address plus enables
  typedef struct packed {
    logic [`WBUF_ADDR_W-1:0] addr;
    logic [`WBUF_DATA_W-1:0] data;
    wbuf_be_t                be;
  } wbuf_req_t;

  // one buffered word with three status bits per byte
  typedef struct packed {
    wbuf_be_t                valid;
    wbuf_be_t                dirty;
    wbuf_be_t                inflight;
    logic [`WBUF_WTAG_W-1:0] wtag;
    logic [`WBUF_DATA_W-1:0] data;
  } wbuf_entry_t;

  // write transaction towards memory
  typedef struct packed {
    logic [`WBUF_WTAG_W-1:0] wtag;
    logic [`WBUF_DATA_W-1:0] data;
    wbuf_be_t                be;
    wbuf_id_t                id;
  } mem_wr_req_t;

  // bookkeeping for one outstanding id
  typedef struct packed {
    logic      vld;
    wbuf_ptr_t ptr;
    wbuf_be_t  be;
  } tx_slot_t;

  // byte state, encoded as {valid, dirty, inflight}
  typedef enum logic [2:0] {
    BYTE_FREE           = 3'b000,
    BYTE_INFLIGHT       = 3'b101,
    BYTE_DIRTY          = 3'b110,
    BYTE_INFLIGHT_DIRTY = 3'b111
  } wbuf_byte_state_e;

endpackage

//--- rtl/wbuf_entry_match.sv
// decode stage: picks the target entry of a core write and the next entry to send
`timescale 1ns/1ps
`include "wbuf_consts.svh"

module wbuf_entry_match import wbuf_pkg::*; (
  input  wbuf_entry_t [`WBUF_DEPTH-1:0] entries_i,
  input  wbuf_req_t                     core_req_i,
  output wbuf_ptr_t                     wr_ptr_o,
  output logic                          wr_ready_o,
  output logic                          send_valid_o,
  output wbuf_ptr_t                     send_ptr_o,
  output wbuf_be_t                      send_be_o
);

  logic [`WBUF_DEPTH-1:0] hit;
  logic [`WBUF_DEPTH-1:0] free;
  logic [`WBUF_DEPTH-1:0] eligible;
  wbuf_ptr_t              hit_ptr;
  wbuf_ptr_t              free_ptr;

  ////////////////////
  // per entry flags
  ////////////////////

  always_comb begin : p_flags
    for (int k = 0; k < `WBUF_DEPTH; k++) begin
      // word address match against any live entry
      hit[k]      = (|entries_i[k].valid) &&
                    (entries_i[k].wtag == core_req_i.addr[`WBUF_ADDR_W-1:3]);
      free[k]     = ~(|entries_i[k].valid);
      // an entry with bytes in flight waits, so two tx of one word never race
      eligible[k] = (|entries_i[k].dirty) && ~(|entries_i[k].inflight);
    end
  end

  ////////////////////
  // fixed priority picks
  ////////////////////

  // walk downwards so the lowest index wins
  always_comb begin : p_pick
    hit_ptr    = '0;
    free_ptr   = '0;
    send_ptr_o = '0;
    for (int k = `WBUF_DEPTH-1; k >= 0; k--) begin
      if (hit[k]) hit_ptr = wbuf_ptr_t'(k);
      if (free[k]) free_ptr = wbuf_ptr_t'(k);
      if (eligible[k]) send_ptr_o = wbuf_ptr_t'(k);
    end
  end

  // coalesce on a hit, else allocate
  assign wr_ptr_o     = (|hit) ? hit_ptr : free_ptr;
  assign wr_ready_o   = (|hit) | (|free);

  // candidate carries its whole dirty mask
  assign send_valid_o = |eligible;
  assign send_be_o    = entries_i[send_ptr_o].dirty;

endmodule

//--- rtl/wbuf_store.sv
// execute stage: entry registers with per byte state, updated by release, send and write
`timescale 1ns/1ps
`include "wbuf_consts.svh"

module wbuf_store import wbuf_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // core write, pointer and ready from decode
  input  logic                          core_req_valid_i,
  input  wbuf_req_t                     core_req_i,
  input  wbuf_ptr_t                     wr_ptr_i,
  input  logic                          wr_ready_i,
  // bytes accepted by memory
  input  logic                          sent_i,
  input  wbuf_ptr_t                     sent_ptr_i,
  input  wbuf_be_t                      sent_be_i,
  // bytes of a returned tx
  input  logic                          release_i,
  input  wbuf_ptr_t                     release_ptr_i,
  input  wbuf_be_t                      release_be_i,
  output wbuf_entry_t [`WBUF_DEPTH-1:0] entries_o,
  output logic                          core_gnt_o,
  output logic                          empty_o
);

  wbuf_entry_t [`WBUF_DEPTH-1:0] entries_d;
  wbuf_entry_t [`WBUF_DEPTH-1:0] entries_q;
  logic                          wr_en;
  logic                          any_valid;

  // grant whenever decode found a hit or a free slot
  assign wr_en      = core_req_valid_i & wr_ready_i;
  assign core_gnt_o = wr_en;
  assign entries_o  = entries_q;

  ////////////////////
  // byte state update
  ////////////////////

  always_comb begin : p_update
    wbuf_byte_state_e st;
    entries_d = entries_q;
    st        = BYTE_FREE;
    for (int k = 0; k < `WBUF_DEPTH; k++) begin
      for (int j = 0; j < `WBUF_BE_W; j++) begin
        st = wbuf_byte_state_e'({entries_q[k].valid[j],
                                 entries_q[k].dirty[j],
                                 entries_q[k].inflight[j]});
        // return of a tx comes first
        if (release_i && (release_ptr_i == wbuf_ptr_t'(k)) && release_be_i[j]) begin
          case (st)
            BYTE_INFLIGHT:       st = BYTE_FREE;
            // rewritten while in flight, goes out again
            BYTE_INFLIGHT_DIRTY: st = BYTE_DIRTY;
            default:             st = st;
          endcase
        end
        // then the bytes memory just took
        if (sent_i && (sent_ptr_i == wbuf_ptr_t'(k)) && sent_be_i[j]) begin
          if (st == BYTE_DIRTY) st = BYTE_INFLIGHT;
        end
        // a new write last, so a byte sent this cycle can turn dirty again
        if (wr_en && (wr_ptr_i == wbuf_ptr_t'(k)) && core_req_i.be[j]) begin
          case (st)
            BYTE_FREE:     st = BYTE_DIRTY;
            BYTE_INFLIGHT: st = BYTE_INFLIGHT_DIRTY;
            default:       st = st;
          endcase
          entries_d[k].data[8*j +: 8] = core_req_i.data[8*j +: 8];
        end
        {entries_d[k].valid[j], entries_d[k].dirty[j], entries_d[k].inflight[j]} = st;
      end
    end
    // tag is rewritten on both a hit and an allocation
    if (wr_en) begin
      entries_d[wr_ptr_i].wtag = core_req_i.addr[`WBUF_ADDR_W-1:3];
    end
  end

  ////////////////////
  // empty flag
  ////////////////////

  always_comb begin : p_empty
    any_valid = 1'b0;
    for (int k = 0; k < `WBUF_DEPTH; k++) begin
      any_valid = any_valid | (|entries_q[k].valid);
    end
  end

  assign empty_o = ~any_valid;

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      entries_q <= '0;
    end else begin
      entries_q <= entries_d;
    end
  end

endmodule

//--- rtl/wbuf_tx_tracker.sv
// result stage: id allocation, memory write port and conversion of returns into releases
`timescale 1ns/1ps
`include "wbuf_consts.svh"

module wbuf_tx_tracker import wbuf_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  wbuf_entry_t [`WBUF_DEPTH-1:0] entries_i,
  input  logic                          send_valid_i,
  input  wbuf_ptr_t                     send_ptr_i,
  input  wbuf_be_t                      send_be_i,
  input  logic                          mem_ack_i,
  input  logic                          mem_rtrn_valid_i,
  input  wbuf_id_t                      mem_rtrn_id_i,
  output logic                          mem_req_valid_o,
  output mem_wr_req_t                   mem_req_o,
  output logic                          sent_o,
  output wbuf_ptr_t                     sent_ptr_o,
  output wbuf_be_t                      sent_be_o,
  output logic                          release_o,
  output wbuf_ptr_t                     release_ptr_o,
  output wbuf_be_t                      release_be_o
);

  tx_slot_t [`WBUF_MAX_TX-1:0] slot_d;
  tx_slot_t [`WBUF_MAX_TX-1:0] slot_q;
  logic                        lock_q;
  wbuf_ptr_t                   lock_ptr_q;
  wbuf_id_t                    lock_id_q;
  logic                        free_any;
  wbuf_id_t                    free_id;
  wbuf_ptr_t                   req_ptr;
  wbuf_id_t                    req_id;
  wbuf_be_t                    req_be;
  logic                        accept;

  // lowest free id
  always_comb begin : p_free_id
    free_any = 1'b0;
    free_id  = '0;
    for (int i = `WBUF_MAX_TX-1; i >= 0; i--) begin
      if (!slot_q[i].vld) begin
        free_any = 1'b1;
        free_id  = wbuf_id_t'(i);
      end
    end
  end

  ////////////////////
  // memory request
  ////////////////////

  // a pending request keeps its entry and id until acked
  // the mask is re-read since a locked entry can only gain dirty bytes
  assign req_ptr         = lock_q ? lock_ptr_q : send_ptr_i;
  assign req_id          = lock_q ? lock_id_q : free_id;
  assign req_be          = lock_q ? entries_i[lock_ptr_q].dirty : send_be_i;
  assign mem_req_valid_o = lock_q | (send_valid_i & free_any);
  assign accept          = mem_req_valid_o & mem_ack_i;

  always_comb begin : p_mem_req
    mem_req_o.wtag = entries_i[req_ptr].wtag;
    mem_req_o.data = entries_i[req_ptr].data;
    mem_req_o.be   = req_be;
    mem_req_o.id   = req_id;
  end

  // send event towards the store
  assign sent_o     = accept;
  assign sent_ptr_o = req_ptr;
  assign sent_be_o  = req_be;

  // a return is handled in its own cycle, no queueing
  assign release_o     = mem_rtrn_valid_i;
  assign release_ptr_o = slot_q[mem_rtrn_id_i].ptr;
  assign release_be_o  = slot_q[mem_rtrn_id_i].be;

  ////////////////////
  // slot table
  ////////////////////

  always_comb begin : p_slots
    slot_d = slot_q;
    if (mem_rtrn_valid_i) slot_d[mem_rtrn_id_i].vld = 1'b0;
    // returned id is outstanding, so it never equals the allocated one
    if (accept) slot_d[req_id] = '{vld: 1'b1, ptr: req_ptr, be: req_be};
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      slot_q <= '0;
      lock_q <= 1'b0;
    end else begin
      slot_q <= slot_d;
      lock_q <= mem_req_valid_o & ~mem_ack_i;
    end
  end

  always_ff @(posedge clk_i) begin : p_lock
    if (mem_req_valid_o && !lock_q) begin
      lock_ptr_q <= req_ptr;
      lock_id_q  <= req_id;
    end
  end

endmodule

//--- rtl/wbuf_top.sv
// store buffer top level, joins decode, store and tracker to the core and memory ports
`timescale 1ns/1ps
`include "wbuf_consts.svh"

module wbuf_top import wbuf_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  // core write port
  input  logic        core_req_valid_i,
  input  wbuf_req_t   core_req_i,
  output logic        core_gnt_o,
  // memory write port and returns
  output logic        mem_req_valid_o,
  output mem_wr_req_t mem_req_o,
  input  logic        mem_ack_i,
  input  logic        mem_rtrn_valid_i,
  input  wbuf_id_t    mem_rtrn_id_i,
  output logic        empty_o
);

  wbuf_entry_t [`WBUF_DEPTH-1:0] entries;
  wbuf_ptr_t                     wr_ptr;
  logic                          wr_ready;
  logic                          send_valid;
  wbuf_ptr_t                     send_ptr;
  wbuf_be_t                      send_be;
  logic                          sent;
  wbuf_ptr_t                     sent_ptr;
  wbuf_be_t                      sent_be;
  logic                          rel_valid;
  wbuf_ptr_t                     rel_ptr;
  wbuf_be_t                      rel_be;

  wbuf_entry_match i_match (
    .entries_i    (entries),
    .core_req_i   (core_req_i),
    .wr_ptr_o     (wr_ptr),
    .wr_ready_o   (wr_ready),
    .send_valid_o (send_valid),
    .send_ptr_o   (send_ptr),
    .send_be_o    (send_be)
  );

  wbuf_store i_store (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .core_req_valid_i (core_req_valid_i),
    .core_req_i       (core_req_i),
    .wr_ptr_i         (wr_ptr),
    .wr_ready_i       (wr_ready),
    .sent_i           (sent),
    .sent_ptr_i       (sent_ptr),
    .sent_be_i        (sent_be),
    .release_i        (rel_valid),
    .release_ptr_i    (rel_ptr),
    .release_be_i     (rel_be),
    .entries_o        (entries),
    .core_gnt_o       (core_gnt_o),
    .empty_o          (empty_o)
  );

  wbuf_tx_tracker i_tracker (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .entries_i        (entries),
    .send_valid_i     (send_valid),
    .send_ptr_i       (send_ptr),
    .send_be_i        (send_be),
    .mem_ack_i        (mem_ack_i),
    .mem_rtrn_valid_i (mem_rtrn_valid_i),
    .mem_rtrn_id_i    (mem_rtrn_id_i),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_o        (mem_req_o),
    .sent_o           (sent),
    .sent_ptr_o       (sent_ptr),
    .sent_be_o        (sent_be),
    .release_o        (rel_valid),
    .release_ptr_o    (rel_ptr),
    .release_be_o     (rel_be)
  );

endmodule

//--- verif/wbuf_assert.sv
// protocol and state checker for the store buffer, bound into the top level
`timescale 1ns/1ps
`include "wbuf_consts.svh"

module wbuf_assert import wbuf_pkg::*; (
  input logic                          clk_i,
  input logic                          rst_ni,
  input logic                          core_req_valid_i,
  input wbuf_req_t                     core_req_i,
  input logic                          core_gnt_o,
  input logic                          mem_req_valid_o,
  input logic                          mem_ack_i,
  input logic                          mem_rtrn_valid_i,
  input wbuf_entry_t [`WBUF_DEPTH-1:0] entries_i
);

  logic       full;
  logic       hit;
  logic       bad_state;
  logic [3:0] tx_cnt_q;

  ////////////////////
  // derived flags
  ////////////////////

  always_comb begin : p_flags
    logic [2:0] st;
    full      = 1'b1;
    hit       = 1'b0;
    bad_state = 1'b0;
    st        = '0;
    for (int k = 0; k < `WBUF_DEPTH; k++) begin
      full = full & (|entries_i[k].valid);
      hit  = hit | ((|entries_i[k].valid) &&
                    (entries_i[k].wtag == core_req_i.addr[`WBUF_ADDR_W-1:3]));
      for (int j = 0; j < `WBUF_BE_W; j++) begin
        st = {entries_i[k].valid[j], entries_i[k].dirty[j], entries_i[k].inflight[j]};
        if (!(st inside {BYTE_FREE, BYTE_DIRTY, BYTE_INFLIGHT, BYTE_INFLIGHT_DIRTY})) begin
          bad_state = 1'b1;
        end
      end
    end
  end

  // accepted minus returned ids
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_tx_cnt
    if (!rst_ni) begin
      tx_cnt_q <= '0;
    end else begin
      tx_cnt_q <= tx_cnt_q + 4'(mem_req_valid_o & mem_ack_i) - 4'(mem_rtrn_valid_i);
    end
  end

  ////////////////////
  // properties
  ////////////////////

  a_full_miss : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (core_req_valid_i && core_gnt_o && full) |-> hit)
    else $error("write granted to a missing word while the buffer is full");

  a_tx_count : assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_cnt_q <= 4'(`WBUF_MAX_TX))
    else $error("more ids outstanding than transaction slots");

  a_byte_state : assert property (@(posedge clk_i) disable iff (!rst_ni) !bad_state)
    else $error("illegal byte state in an entry");

endmodule

bind wbuf_top wbuf_assert i_assert (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .core_req_valid_i (core_req_valid_i),
  .core_req_i       (core_req_i),
  .core_gnt_o       (core_gnt_o),
  .mem_req_valid_o  (mem_req_valid_o),
  .mem_ack_i        (mem_ack_i),
  .mem_rtrn_valid_i (mem_rtrn_valid_i),
  .entries_i        (entries)
);

//--- verif/wbuf_tb.sv
// testbench for the store buffer, random core writes against a random memory and a byte model
`timescale 1ns/1ps
`include "wbuf_consts.svh"

module wbuf_tb import wbuf_pkg::*; ();

  localparam int                      NUM_WRITES = 300;
  localparam logic [`WBUF_ADDR_W-1:0] BASE_ADDR  = 32'h0000_1000;

  logic        clk_i;
  logic        rst_ni;
  logic        core_req_valid_i;
  wbuf_req_t   core_req_i;
  logic        core_gnt_o;
  logic        mem_req_valid_o;
  mem_wr_req_t mem_req_o;
  logic        mem_ack_i;
  logic        mem_rtrn_valid_i;
  wbuf_id_t    mem_rtrn_id_i;
  logic        empty_o;

  // reference model, keyed by byte address
  logic [7:0] latest_q  [logic [`WBUF_ADDR_W-1:0]];
  logic [7:0] mem_img_q [logic [`WBUF_ADDR_W-1:0]];
  // ids accepted by memory and not yet returned
  wbuf_id_t   out_ids [$];
  bit         silent;
  int         main_errs = 0;
  int         mon_errs  = 0;

  wbuf_top UUT (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .core_req_valid_i (core_req_valid_i),
    .core_req_i       (core_req_i),
    .core_gnt_o       (core_gnt_o),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_o        (mem_req_o),
    .mem_ack_i        (mem_ack_i),
    .mem_rtrn_valid_i (mem_rtrn_valid_i),
    .mem_rtrn_id_i    (mem_rtrn_id_i),
    .empty_o          (empty_o)
  );

  initial begin : p_clk
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////
  // helpers
  ////////////////////

  task automatic expect_bit(input string name, input logic exp, input logic act);
    assert (act === exp) else begin
      main_errs++;
      $display("FAILED %s expected %0b actual %0b", name, exp, act);
    end
  endtask

  // random write to word w of the test window
  function automatic wbuf_req_t random_req(input int w);
    wbuf_req_t r;
    r.addr = BASE_ADDR + 32'(w * 8) + 32'($urandom % 8);
    r.data = {$urandom, $urandom};
    r.be   = 8'($urandom);
    // at least one byte, so a write always holds its word
    if (r.be == '0) begin
      r.be = 8'h01;
    end
    return r;
  endfunction

  // core side handshake, request held until granted or out of time
  task automatic write_word(input wbuf_req_t req, input int limit, output bit granted);
    int n;
    granted = 1'b0;
    n       = 0;
    @(posedge clk_i);
    core_req_valid_i <= 1'b1;
    core_req_i       <= req;
    while (!granted && n < limit) begin
      @(negedge clk_i);
      granted = core_gnt_o;
      n++;
      @(posedge clk_i);
    end
    core_req_valid_i <= 1'b0;
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin : p_main
    bit granted;
    int w;
    int n;
    void'($urandom(16));
    silent           = 1'b1;
    rst_ni           <= 1'b0;
    core_req_valid_i <= 1'b0;
    core_req_i       <= '0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    expect_bit("reset_empty", 1'b1, empty_o);
    expect_bit("reset_gnt", 1'b0, core_gnt_o);
    expect_bit("reset_mem_req", 1'b0, mem_req_valid_o);

    // fill every entry while memory is silent
    for (w = 0; w < `WBUF_DEPTH; w++) begin
      write_word(random_req(w), 20, granted);
      expect_bit("bp_fill", 1'b1, granted);
    end
    // new word finds no room
    write_word(random_req(`WBUF_DEPTH), 20, granted);
    expect_bit("bp_blocked", 1'b0, granted);
    // a held word still coalesces
    write_word(random_req(0), 20, granted);
    expect_bit("bp_coalesce", 1'b1, granted);
    @(negedge clk_i);
    silent = 1'b0;
    write_word(random_req(`WBUF_DEPTH), 1000, granted);
    expect_bit("bp_release", 1'b1, granted);

    // random writes over six words
    for (n = 0; n < NUM_WRITES; n++) begin
      w = int'($urandom % 6);
      write_word(random_req(w), 1000, granted);
      assert (granted) else begin
        main_errs++;
        $display("write %0d was not granted within 1000 cycles", n);
      end
      repeat (int'($urandom % 3)) @(posedge clk_i);
    end

    // drain
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!empty_o && n < 2000);
    assert (empty_o) else begin
      main_errs++;
      $display("buffer did not drain within 2000 cycles");
    end
    foreach (latest_q[a]) begin
      assert (mem_img_q.exists(a)) else begin
        main_errs++;
        $display("byte %h was written but never reached memory", a);
      end
      if (mem_img_q.exists(a)) begin
        assert (mem_img_q[a] == latest_q[a]) else begin
          main_errs++;
          $display("FAILED final_image byte %h expected %h actual %h",
                   a, latest_q[a], mem_img_q[a]);
        end
      end
    end

    $display("errors: sequence %0d, monitor %0d", main_errs, mon_errs);
    if (main_errs + mon_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  ////////////////////
  // memory responder
  ////////////////////

  // random acks, returns drawn from the outstanding ids in any order
  initial begin : p_responder
    int pick;
    mem_ack_i        <= 1'b0;
    mem_rtrn_valid_i <= 1'b0;
    mem_rtrn_id_i    <= '0;
    forever begin
      @(posedge clk_i);
      if (silent || !rst_ni) begin
        mem_ack_i        <= 1'b0;
        mem_rtrn_valid_i <= 1'b0;
      end else begin
        mem_ack_i <= ($urandom % 3) == 0;
        if (out_ids.size() > 0 && ($urandom % 2) == 0) begin
          pick = int'($urandom % out_ids.size());
          mem_rtrn_valid_i <= 1'b1;
          mem_rtrn_id_i    <= out_ids[pick];
        end else begin
          mem_rtrn_valid_i <= 1'b0;
        end
      end
    end
  end

  ////////////////////
  // monitor and model
  ////////////////////

  // sampled mid cycle, ahead of the edge that completes each transfer
  always @(negedge clk_i) begin : p_monitor
    logic [`WBUF_ADDR_W-1:0] key;
    logic [7:0]              act;
    bit                      found;
    int                      idx;
    if (rst_ni) begin
      if (mem_req_valid_o) begin
        assert (out_ids.size() < `WBUF_MAX_TX) else begin
          mon_errs++;
          $display("memory request valid while all ids are outstanding");
        end
      end
      // accepted request, compared before this cycle's core write
      if (mem_req_valid_o && mem_ack_i) begin
        for (int j = 0; j < `WBUF_BE_W; j++) begin
          if (mem_req_o.be[j]) begin
            key = {mem_req_o.wtag, 3'(j)};
            act = mem_req_o.data[8*j +: 8];
            assert (latest_q.exists(key)) else begin
              mon_errs++;
              $display("memory request carries byte %h that the core never wrote", key);
            end
            if (latest_q.exists(key)) begin
              assert (act == latest_q[key]) else begin
                mon_errs++;
                $display("FAILED mem_data byte %h expected %h actual %h",
                         key, latest_q[key], act);
              end
            end
            mem_img_q[key] = act;
          end
        end
        found = 1'b0;
        foreach (out_ids[i]) begin
          if (out_ids[i] == mem_req_o.id) found = 1'b1;
        end
        assert (!found) else begin
          mon_errs++;
          $display("id %0d reused while still outstanding", mem_req_o.id);
        end
        out_ids.push_back(mem_req_o.id);
        assert (out_ids.size() <= `WBUF_MAX_TX) else begin
          mon_errs++;
          $display("FAILED outstanding_ids expected <= %0d actual %0d",
                   `WBUF_MAX_TX, out_ids.size());
        end
      end
      // return retires its id
      if (mem_rtrn_valid_i) begin
        idx = -1;
        foreach (out_ids[i]) begin
          if (out_ids[i] == mem_rtrn_id_i) idx = i;
        end
        if (idx >= 0) out_ids.delete(idx);
      end
      // granted core write updates the latest byte values
      if (core_req_valid_i && core_gnt_o) begin
        for (int j = 0; j < `WBUF_BE_W; j++) begin
          if (core_req_i.be[j]) begin
            key = {core_req_i.addr[`WBUF_ADDR_W-1:3], 3'(j)};
            latest_q[key] = core_req_i.data[8*j +: 8];
          end
        end
      end
    end
  end

endmodule

//--- wbuf_top.f
+incdir+rtl
rtl/wbuf_pkg.sv
rtl/wbuf_entry_match.sv
rtl/wbuf_store.sv
rtl/wbuf_tx_tracker.sv
rtl/wbuf_top.sv
verif/wbuf_assert.sv
verif/wbuf_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the store buffer testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
  --top-module wbuf_tb -f wbuf_top.f \
  --Mdir "$OBJ" -o wbuf_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$OBJ/wbuf_sim" > "$LOG" 2>&1
rc=$?
cat "$LOG"
if [ $rc -ne 0 ]; then
  echo "simulation exited with status $rc"
  exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q "STATUS: PASS" "$LOG"; then
  echo "no result line in $LOG"
  exit 1
fi
exit 0
